// ==== bench/special_move_gen_tb.sv ====
module special_move_gen_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int board_count = 200;
	localparam int cycles_per_board = 60;

	logic clk = 1'b0;
	logic reset;
	logic [chess_board_pkg::board_width-1:0] board;
	logic king_side_ok;
	logic queen_side_ok;
	logic [7:0] ep_files;
	logic rden;
	logic [move_code_pkg::move_bits-1:0] move_out;
	logic fifo_empty;
	logic done;

	logic [31:0] lfsr_state = 32'h1bc40f43;
	logic [move_code_pkg::move_bits-1:0] expected[$];
	int castle_words = 0;
	int ep_words = 0;

	special_move_gen dut_i (
		.clk(clk),
		.reset(reset),
		.board(board),
		.king_side_ok(king_side_ok),
		.queen_side_ok(queen_side_ok),
		.ep_files(ep_files),
		.rden(rden),
		.move_out(move_out),
		.fifo_empty(fifo_empty),
		.done(done)
	);

	always #50 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("FAILED at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
		$display("STATUS: FAIL");
		$fatal;
	endtask

	task automatic report_problem(input string what);
		$display("at %0t ns: %s", $time, what);
		$display("STATUS: FAIL");
		$fatal;
	endtask

	task automatic put_square(input int col, input int row, input logic [3:0] sq);
		board[(row * 8 + col) * 4 +: 4] = sq;
	endtask

	function automatic logic [3:0] get_square(input int col, input int row);
		get_square = board[(row * 8 + col) * 4 +: 4];
	endfunction

	function automatic logic is_vacant(input int col, input int row);
		logic [3:0] sq;
		sq = get_square(col, row);
		is_vacant = sq[2:0] == chess_board_pkg::empty; // colour is don't care
	endfunction

	// column in the high bits, row in the low bits
	function automatic logic [5:0] square_code(input int col, input int row);
		logic [2:0] c;
		logic [2:0] r;
		c = col[2:0];
		r = row[2:0];
		square_code = {c, r};
	endfunction

	task automatic random_board();
		logic [31:0] v;
		logic [31:0] pick;
		for (int i = 0; i < 64; i++) begin
			take_bits(4, v);
			board[i * 4 +: 4] = v[3:0];
		end
		// rank 1 leans toward a castling layout, 3 in 4
		for (int col = 0; col < 8; col++) begin
			take_bits(2, pick);
			if (pick[1:0] != 2'b00) begin
				if (col == 4) begin
					put_square(col, 0, {chess_board_pkg::white, chess_board_pkg::king});
				end else if (col == 0 || col == 7) begin
					put_square(col, 0, {chess_board_pkg::white, chess_board_pkg::rook});
				end else begin
					take_bits(1, v);
					put_square(col, 0, {v[0], chess_board_pkg::empty}); // colour is don't care
				end
			end
		end
		for (int col = 0; col < 8; col++) begin
			take_bits(1, pick);
			if (pick[0]) put_square(col, 4, {chess_board_pkg::white, chess_board_pkg::pawn});
		end
		take_bits(1, v);
		king_side_ok = v[0];
		take_bits(1, v);
		queen_side_ok = v[0];
		take_bits(8, v);
		ep_files = v[7:0];
	endtask

	// reference list in slot order
	task automatic build_expected();
		logic [6:0] castle_bits;
		logic [6:0] ep_bits;
		logic [3:0] w_pawn;
		logic k_home;
		castle_bits = 7'b0000010;
		ep_bits = 7'b0010101; // pawn move, en passant, capture
		w_pawn = {chess_board_pkg::white, chess_board_pkg::pawn};
		k_home = get_square(4, 0) == {chess_board_pkg::white, chess_board_pkg::king};
		expected.delete();
		if (king_side_ok && k_home && is_vacant(5, 0) && is_vacant(6, 0)
				&& get_square(7, 0) == {chess_board_pkg::white, chess_board_pkg::rook}) begin
			expected.push_back({castle_bits, square_code(4, 0), square_code(6, 0)});
			castle_words++;
		end
		if (queen_side_ok && k_home && is_vacant(1, 0)
				&& is_vacant(2, 0) && is_vacant(3, 0)
				&& get_square(0, 0) == {chess_board_pkg::white, chess_board_pkg::rook}) begin
			expected.push_back({castle_bits, square_code(4, 0), square_code(2, 0)});
			castle_words++;
		end
		for (int c = 0; c < 8; c++) begin
			if (ep_files[c] && c > 0) begin
				if (get_square(c - 1, 4) == w_pawn) begin
					expected.push_back({ep_bits, square_code(c - 1, 4), square_code(c, 5)});
					ep_words++;
				end
			end
			if (ep_files[c] && c < 7) begin
				if (get_square(c + 1, 4) == w_pawn) begin
					expected.push_back({ep_bits, square_code(c + 1, 4), square_code(c, 5)});
					ep_words++;
				end
			end
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic check_idle();
		assert (done == 1'b0) else report_mismatch("done", 32'(done), 32'd0);
		assert (fifo_empty == 1'b1) else report_mismatch("fifo_empty", 32'(fifo_empty), 32'd1);
	endtask

	// early_pop reads as soon as a word shows, otherwise waits for done
	task automatic run_board(input logic early_pop);
		int popped;
		reset = 1'b1;
		rden = 1'b0;
		random_board();
		build_expected();
		for (int i = 0; i < 10; i++) begin
			next_cycle();
			check_idle();
		end
		reset = 1'b0;
		next_cycle();
		check_idle();
		popped = 0;
		while (!(done && popped == expected.size())) begin
			assert (!(done && fifo_empty))
				else report_problem("FIFO ran empty after done with moves still missing");
			if ((early_pop || done) && !fifo_empty) begin
				assert (popped < expected.size())
					else report_problem("FIFO holds more moves than expected");
				assert (move_out == expected[popped])
					else report_mismatch("move_out", 32'(move_out), 32'(expected[popped]));
				rden = 1'b1;
				popped++;
			end else begin
				rden = 1'b0;
			end
			next_cycle();
		end
		rden = 1'b0;
		for (int i = 0; i < 4; i++) begin
			assert (fifo_empty == 1'b1)
				else report_problem("FIFO shows a move beyond the expected count");
			assert (done == 1'b1) else report_mismatch("done", 32'(done), 32'd1);
			next_cycle();
		end
	endtask

	initial begin
		reset = 1'b1;
		board = '0;
		king_side_ok = 1'b0;
		queen_side_ok = 1'b0;
		ep_files = '0;
		rden = 1'b0;
		for (int b = 0; b < board_count; b++) begin
			run_board(b[0]);
		end
		$display("%0d boards, %0d castling and %0d en passant moves checked",
			board_count, castle_words, ep_words);
		$display("STATUS: PASS");
		$finish;
	end

	initial begin
		#(board_count * cycles_per_board * 100);
		$display("timeout: the run did not finish in time, done or a move never arrived");
		$display("STATUS: FAIL");
		$fatal;
	end

endmodule

// ==== flist.f ====
logic/chess_board_pkg.sv
logic/move_code_pkg.sv
logic/special_move_finder.sv
logic/move_serializer.sv
logic/move_fifo.sv
logic/special_move_gen.sv
bench/special_move_gen_tb.sv

// ==== logic/chess_board_pkg.sv ====
package chess_board_pkg;

	// packed board, 64 squares of 4 bits each
	localparam int board_width = 256;
	localparam int square_bits = 4;
	localparam int piece_bits = 3;
	localparam int coord_bits = 3;
	localparam int board_files = 8;

	// a square is {colour, piece}, index is row*8 + col
	// col 0 is file a, row 0 is rank 1

	localparam logic white = 1'b0;
	localparam logic black = 1'b1;

	localparam logic [piece_bits-1:0] empty = 3'd0;
	localparam logic [piece_bits-1:0] pawn = 3'd1;
	localparam logic [piece_bits-1:0] knight = 3'd2;
	localparam logic [piece_bits-1:0] bishop = 3'd3;
	localparam logic [piece_bits-1:0] rook = 3'd4;
	localparam logic [piece_bits-1:0] queen = 3'd5;
	localparam logic [piece_bits-1:0] king = 3'd6;

	// rows used by the special moves
	localparam int row_home = 0; // rank 1
	localparam int row_ep_from = 4; // rank 5, capturing pawn
	localparam int row_ep_to = 5; // rank 6, landing square

	// columns used by the special moves
	localparam int col_a = 0;
	localparam int col_e = 4;
	localparam int col_h = 7;

endpackage

// ==== logic/move_code_pkg.sv ====
package move_code_pkg;

	// move word is {flag, from, to}
	localparam int flag_bits = 7;
	localparam int square_code_bits = 6; // {col, row}
	localparam int move_bits = flag_bits + 2 * square_code_bits;

	// flag bit positions
	localparam int flag_invalid = 6;
	localparam int flag_promote = 5;
	localparam int flag_pawn_move = 4;
	localparam int flag_double_step = 3;
	localparam int flag_en_passant = 2;
	localparam int flag_castle = 1;
	localparam int flag_capture = 0;

	localparam logic [flag_bits-1:0] castle_flag = flag_bits'(1 << flag_castle);
	localparam logic [flag_bits-1:0] en_passant_flag =
		flag_bits'((1 << flag_pawn_move) | (1 << flag_en_passant) | (1 << flag_capture));

	// candidate slots, ep capture onto col c sits at 2+2c (from left) and 3+2c (from right)
	localparam int slot_count = 18;
	localparam int slot_king_side = 0;
	localparam int slot_queen_side = 1;
	localparam int slot_ep_base = 2;

	// never fills, holds every slot at once
	localparam int fifo_depth = 32;

endpackage

// ==== logic/move_fifo.sv ====
module move_fifo #(
	parameter int depth = move_code_pkg::fifo_depth
) (
	input  logic clk,
	input  logic reset,
	input  logic wr_en,
	input  logic [move_code_pkg::move_bits-1:0] wr_move,
	input  logic rden,
	output logic [move_code_pkg::move_bits-1:0] move_out,
	output logic fifo_empty
);

	localparam int ptr_bits = $clog2(depth);
	localparam int count_bits = $clog2(depth + 1);

	logic [move_code_pkg::move_bits-1:0] mem [depth];
	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic [count_bits-1:0] count;
	logic do_read;

	assign fifo_empty = (count == '0);
	assign move_out = mem[rd_ptr]; // show-ahead head
	assign do_read = rden && !fifo_empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_read) rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr_en && !do_read) count <= count + 1'b1;
			else if (do_read && !wr_en) count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) mem[wr_ptr] <= wr_move;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> count != count_bits'(depth));

	// reader must wait for a word
	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		rden |-> !fifo_empty);

endmodule

// ==== logic/move_serializer.sv ====
module move_serializer (
	input  logic clk,
	input  logic reset,
	input  logic [move_code_pkg::slot_count-1:0] slot_valid,
	input  logic [move_code_pkg::slot_count-1:0][move_code_pkg::move_bits-1:0] slot_moves,
	input  logic load,
	output logic wr_en,
	output logic [move_code_pkg::move_bits-1:0] wr_move,
	output logic done
);

	localparam int slots = move_code_pkg::slot_count;
	localparam int idx_bits = $clog2(slots);

	logic [slots-1:0] pending;
	logic [slots-1:0] src; // mask seen this cycle
	logic [slots-1:0] low_bit;
	logic [idx_bits-1:0] low_idx;
	logic started;

	always_comb begin
		src = load ? slot_valid : pending;
		low_bit = src & (~src + 1'b1); // lowest set bit only
		low_idx = '0;
		for (int i = slots - 1; i >= 0; i--) begin
			if (src[i]) low_idx = idx_bits'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= '0;
			started <= 1'b0;
			wr_en <= 1'b0;
			done <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (load) started <= 1'b1;
			if (load || (started && !done)) begin
				if (|src) begin
					wr_en <= 1'b1;
					pending <= src & ~low_bit;
				end else begin
					done <= 1'b1; // mask drained
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (|src) wr_move <= slot_moves[low_idx];
	end

	// no word goes out while done is up
	a_no_write_after_done: assert property (@(posedge clk) disable iff (reset)
		done |-> !wr_en);

endmodule

// ==== logic/special_move_finder.sv ====
module special_move_finder (
	input  logic clk,
	input  logic reset,
	input  logic [chess_board_pkg::board_width-1:0] board,
	input  logic king_side_ok,
	input  logic queen_side_ok,
	input  logic [chess_board_pkg::board_files-1:0] ep_files,
	output logic [move_code_pkg::slot_count-1:0] slot_valid,
	output logic [move_code_pkg::slot_count-1:0][move_code_pkg::move_bits-1:0] slot_moves,
	output logic load
);

	localparam int bw = chess_board_pkg::board_width;
	localparam int sb = chess_board_pkg::square_bits;
	localparam int cb = chess_board_pkg::coord_bits;
	localparam int files = chess_board_pkg::board_files;
	localparam int ep_base = move_code_pkg::slot_ep_base;
	localparam logic [sb-1:0] white_king = {chess_board_pkg::white, chess_board_pkg::king};
	localparam logic [sb-1:0] white_rook = {chess_board_pkg::white, chess_board_pkg::rook};
	localparam logic [sb-1:0] white_pawn = {chess_board_pkg::white, chess_board_pkg::pawn};

	logic [move_code_pkg::slot_count-1:0] cand_valid;
	logic [move_code_pkg::slot_count-1:0][move_code_pkg::move_bits-1:0] cand_moves;
	logic loaded;

	function automatic logic [sb-1:0] square_at(input logic [bw-1:0] b, input int col, input int row);
		square_at = b[(row * files + col) * sb +: sb];
	endfunction

	function automatic logic is_empty(input logic [bw-1:0] b, input int col, input int row);
		logic [sb-1:0] sq;
		sq = square_at(b, col, row);
		is_empty = (sq[chess_board_pkg::piece_bits-1:0] == chess_board_pkg::empty); // colour ignored
	endfunction

	function automatic logic [move_code_pkg::square_code_bits-1:0] square_code(input int col,
			input int row);
		logic [cb-1:0] c;
		logic [cb-1:0] r;
		c = cb'(col);
		r = cb'(row);
		square_code = {c, r};
	endfunction

	// castling, no check or attacked-square test here
	assign cand_valid[move_code_pkg::slot_king_side] = king_side_ok
		&& square_at(board, chess_board_pkg::col_e, chess_board_pkg::row_home) == white_king
		&& is_empty(board, chess_board_pkg::col_e + 1, chess_board_pkg::row_home)
		&& is_empty(board, chess_board_pkg::col_e + 2, chess_board_pkg::row_home)
		&& square_at(board, chess_board_pkg::col_h, chess_board_pkg::row_home) == white_rook;
	assign cand_moves[move_code_pkg::slot_king_side] = {move_code_pkg::castle_flag,
		square_code(chess_board_pkg::col_e, chess_board_pkg::row_home),
		square_code(chess_board_pkg::col_e + 2, chess_board_pkg::row_home)}; // e1 to g1

	assign cand_valid[move_code_pkg::slot_queen_side] = queen_side_ok
		&& square_at(board, chess_board_pkg::col_e, chess_board_pkg::row_home) == white_king
		&& is_empty(board, chess_board_pkg::col_a + 1, chess_board_pkg::row_home)
		&& is_empty(board, chess_board_pkg::col_a + 2, chess_board_pkg::row_home)
		&& is_empty(board, chess_board_pkg::col_a + 3, chess_board_pkg::row_home)
		&& square_at(board, chess_board_pkg::col_a, chess_board_pkg::row_home) == white_rook;
	assign cand_moves[move_code_pkg::slot_queen_side] = {move_code_pkg::castle_flag,
		square_code(chess_board_pkg::col_e, chess_board_pkg::row_home),
		square_code(chess_board_pkg::col_e - 2, chess_board_pkg::row_home)}; // e1 to c1

	// en passant onto column c, capturing pawn from either neighbour
	for (genvar c = 0; c < files; c++) begin : g_ep
		if (c > chess_board_pkg::col_a) begin : g_from_left
			assign cand_valid[ep_base + 2 * c] = ep_files[c]
				&& square_at(board, c - 1, chess_board_pkg::row_ep_from) == white_pawn;
			assign cand_moves[ep_base + 2 * c] = {move_code_pkg::en_passant_flag,
				square_code(c - 1, chess_board_pkg::row_ep_from),
				square_code(c, chess_board_pkg::row_ep_to)};
		end else begin : g_left_edge
			assign cand_valid[ep_base + 2 * c] = 1'b0; // off the a-file edge
			assign cand_moves[ep_base + 2 * c] = '0;
		end
		if (c < chess_board_pkg::col_h) begin : g_from_right
			assign cand_valid[ep_base + 2 * c + 1] = ep_files[c]
				&& square_at(board, c + 1, chess_board_pkg::row_ep_from) == white_pawn;
			assign cand_moves[ep_base + 2 * c + 1] = {move_code_pkg::en_passant_flag,
				square_code(c + 1, chess_board_pkg::row_ep_from),
				square_code(c, chess_board_pkg::row_ep_to)};
		end else begin : g_right_edge
			assign cand_valid[ep_base + 2 * c + 1] = 1'b0;
			assign cand_moves[ep_base + 2 * c + 1] = '0;
		end
	end

	// capture once after reset, then hold
	always_ff @(posedge clk) begin
		if (reset) begin
			loaded <= 1'b0;
			load <= 1'b0;
			slot_valid <= '0;
		end else begin
			load <= !loaded;
			if (!loaded) begin
				loaded <= 1'b1;
				slot_valid <= cand_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!loaded) slot_moves <= cand_moves;
	end

	// load only ever follows a reset release by one edge
	a_load_once: assert property (@(posedge clk) disable iff (reset)
		load |-> $past(reset, 2) && !$past(reset));

endmodule

// ==== logic/special_move_gen.sv ====
module special_move_gen (
	input  logic clk,
	input  logic reset,
	input  logic [chess_board_pkg::board_width-1:0] board,
	input  logic king_side_ok,
	input  logic queen_side_ok,
	input  logic [chess_board_pkg::board_files-1:0] ep_files,
	input  logic rden,
	output logic [move_code_pkg::move_bits-1:0] move_out,
	output logic fifo_empty,
	output logic done
);

	logic [move_code_pkg::slot_count-1:0] slot_valid;
	logic [move_code_pkg::slot_count-1:0][move_code_pkg::move_bits-1:0] slot_moves;
	logic load;
	logic wr_en;
	logic [move_code_pkg::move_bits-1:0] wr_move;

	special_move_finder finder_i (
		.clk(clk),
		.reset(reset),
		.board(board),
		.king_side_ok(king_side_ok),
		.queen_side_ok(queen_side_ok),
		.ep_files(ep_files),
		.slot_valid(slot_valid),
		.slot_moves(slot_moves),
		.load(load)
	);

	move_serializer serializer_i (
		.clk(clk),
		.reset(reset),
		.slot_valid(slot_valid),
		.slot_moves(slot_moves),
		.load(load),
		.wr_en(wr_en),
		.wr_move(wr_move),
		.done(done)
	);

	move_fifo #(.depth(move_code_pkg::fifo_depth)) fifo_i (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_move(wr_move),
		.rden(rden),
		.move_out(move_out),
		.fifo_empty(fifo_empty)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module special_move_gen_tb -f flist.f &&
	./obj_dir/Vspecial_move_gen_tb | tee /dev/stderr | grep -q "STATUS: PASS" &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
